/* src/nocPkg.sv */
package nocPkg;

  localparam int numPorts = 5;
  localparam int payloadWidth = 16;

  // Length counts the head flit itself, 1 to 15
  localparam int lenWidth = 4;

  typedef enum logic [0:0] {
    Head = 1'b0,
    Body = 1'b1
  } flitKindT;

  // Numbered in arbitration order
  typedef enum logic [2:0] {
    PortLocal = 3'd0,
    PortNorth = 3'd1,
    PortEast  = 3'd2,
    PortWest  = 3'd3,
    PortSouth = 3'd4
  } portIdT;

  // Head flits carry the packet length in payload[lenWidth-1:0]
  typedef struct packed {
    flitKindT                kind;
    logic [payloadWidth-1:0] payload;
  } flitT;

  // What a channel offers to the switch arbiter
  typedef struct packed {
    logic valid;
    logic last;
    flitT flit;
  } chanReqT;

  // Output word tagged with its source port
  typedef struct packed {
    flitT   flit;
    portIdT srcPort;
  } outFlitT;

  // Serve states sit one above the matching portIdT value
  typedef enum logic [2:0] {
    Idle       = 3'd0,
    ServeLocal = 3'd1,
    ServeNorth = 3'd2,
    ServeEast  = 3'd3,
    ServeWest  = 3'd4,
    ServeSouth = 3'd5
  } arbStateT;

endpackage

/* src/inputChannel.sv */
`timescale 1ns/100ps

module inputChannel #(
  parameter int fifoDepth = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            inValid,
  input  nocPkg::flitT    inFlit,
  output logic            inReady,
  output nocPkg::chanReqT req,
  input  logic            pop
);

  localparam int ptrWidth = $clog2(fifoDepth);
  localparam logic [ptrWidth:0] fullCount = (ptrWidth + 1)'(fifoDepth);
  localparam logic [nocPkg::lenWidth-1:0] lenOne = 1;

  if (fifoDepth < 2 || (fifoDepth & (fifoDepth - 1)) != 0)
  begin : depthCheck
    $error("fifoDepth must be a power of two of 2 or more");
  end

  nocPkg::flitT mem [fifoDepth];
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth:0] count;
  logic wrEn;
  logic full;
  logic empty;

  nocPkg::flitT headFlit;
  logic [nocPkg::lenWidth-1:0] lenReg;
  logic [nocPkg::lenWidth-1:0] flitCnt;
  logic headLast;
  logic bodyLast;
  logic isLast;

  assign full = count == fullCount;
  assign empty = count == '0;
  assign inReady = !full;
  assign wrEn = inValid && !full;

  // Circular flit storage
  always_ff @(posedge clk)
  begin
    if (wrEn)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (wrEn)
        wrPtr <= wrPtr + 1'b1;
      if (pop)
        rdPtr <= rdPtr + 1'b1;
      case ({wrEn, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign headFlit = mem[rdPtr];

  // A head of length 1 is a whole packet
  assign headLast = headFlit.payload[nocPkg::lenWidth-1:0] == lenOne;
  // Timer holds the number of flits already forwarded
  assign bodyLast = flitCnt == (lenReg - lenOne);
  assign isLast = (headFlit.kind == nocPkg::Head) ? headLast : bodyLast;

  assign req.valid = !empty;
  assign req.last = isLast;
  assign req.flit = headFlit;

  // Length capture and flit timer
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lenReg <= '0;
      flitCnt <= '0;
    end
    else if (pop)
    begin
      if (headFlit.kind == nocPkg::Head)
        lenReg <= headFlit.payload[nocPkg::lenWidth-1:0];
      if (isLast)
        flitCnt <= '0;
      else
        flitCnt <= flitCnt + 1'b1;
    end
  end

  // A flit refused while full is offered again unchanged
  noWriteWhenFull: assert property (
    @(posedge clk) disable iff (rst)
    inValid && full |=> inValid && $stable(inFlit)
  );

  // Arbiter must only drain a channel that has a flit
  popOnlyWhenValid: assert property (
    @(posedge clk) disable iff (rst)
    pop |-> req.valid
  );

endmodule

/* src/switchArbiter.sv */
`timescale 1ns/100ps

module switchArbiter (
  input  logic                        clk,
  input  logic                        rst,
  input  nocPkg::chanReqT             req [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] pop,
  output logic                        outValid,
  output nocPkg::outFlitT             outFlit,
  input  logic                        outReady
);

  nocPkg::arbStateT state;
  nocPkg::arbStateT stateNext;
  nocPkg::portIdT lastServed;
  nocPkg::portIdT lastNext;
  nocPkg::portIdT curPort;
  nocPkg::portIdT pick;
  logic serving;
  logic found;
  logic canLoad;
  logic popAny;
  logic popLast;
  logic [nocPkg::numPorts-1:0] cand;

  // Unused encodings behave like Idle
  assign serving = (state != nocPkg::Idle) && (state <= nocPkg::ServeSouth);
  assign curPort = serving ? nocPkg::portIdT'(state - 3'd1) : nocPkg::PortLocal;

  // Output register free or draining this cycle
  assign canLoad = !outValid || outReady;

  always_comb
  begin
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      pop[i] = serving && (int'(curPort) == i) && req[i].valid && canLoad;
    end
  end

  assign popAny = |pop;
  assign popLast = popAny && req[curPort].last;

  // The port whose packet ends now competes again only from Idle
  always_comb
  begin
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      cand[i] = req[i].valid && !(serving && int'(curPort) == i);
    end
  end

  // Round robin search starting after lastServed
  always_comb
  begin
    int idx;
    found = 1'b0;
    pick = lastServed;
    // Walk backwards so the nearest candidate wins
    for (int k = nocPkg::numPorts; k >= 1; k--)
    begin
      idx = (int'(lastServed) + k) % nocPkg::numPorts;
      if (cand[idx])
      begin
        found = 1'b1;
        pick = nocPkg::portIdT'(idx[2:0]);
      end
    end
  end

  always_comb
  begin
    stateNext = state;
    lastNext = lastServed;
    if (!serving || popLast)
    begin
      if (found)
      begin
        stateNext = nocPkg::arbStateT'(pick + 3'd1);
        lastNext = pick;
      end
      else
      begin
        stateNext = nocPkg::Idle;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= nocPkg::Idle;
      lastServed <= nocPkg::PortSouth;
      outValid <= 1'b0;
    end
    else
    begin
      state <= stateNext;
      lastServed <= lastNext;
      if (canLoad)
        outValid <= popAny;
    end
  end

  // Output word is loaded only on a pop
  always_ff @(posedge clk)
  begin
    if (popAny)
    begin
      outFlit.flit <= req[curPort].flit;
      outFlit.srcPort <= curPort;
    end
  end

  popOneHot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(pop)
  );

  outHeldUnderStall: assert property (
    @(posedge clk) disable iff (rst)
    outValid && !outReady |=> outValid && $stable(outFlit)
  );

  // Mid packet the grant stays put, so only the same channel may pop next
  grantHeldToLast: assert property (
    @(posedge clk) disable iff (rst)
    popAny && !popLast |=> $stable(state) && (pop == '0 || pop == $past(pop))
  );

endmodule

/* src/routerOutputPort.sv */
`timescale 1ns/100ps

module routerOutputPort #(
  parameter int fifoDepth = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::numPorts-1:0] inValid,
  input  nocPkg::flitT                inFlit [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] inReady,
  output logic                        outValid,
  output nocPkg::outFlitT             outFlit,
  input  logic                        outReady
);

  nocPkg::chanReqT req [nocPkg::numPorts];
  logic [nocPkg::numPorts-1:0] pop;

  // One buffered channel per port, in arbitration order
  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : chan_g
    inputChannel #(
      .fifoDepth(fifoDepth)
    ) channel (
      .clk    (clk),
      .rst    (rst),
      .inValid(inValid[i]),
      .inFlit (inFlit[i]),
      .inReady(inReady[i]),
      .req    (req[i]),
      .pop    (pop[i])
    );
  end

  switchArbiter arbiter (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .pop     (pop),
    .outValid(outValid),
    .outFlit (outFlit),
    .outReady(outReady)
  );

endmodule

/* tests/outputPortTb.sv */
`timescale 1ns/100ps

module outputPortTb;

  typedef nocPkg::flitT flitListT[$];

  typedef struct packed {
    logic [15:0] seq;
    logic [3:0]  len;
    logic [3:0]  gap;
  } pktDescT;

  typedef enum {ModeReady, ModeHold, ModeLight, ModeHeavy} stallModeT;

  logic clk = 1'b0;
  logic rst;
  logic [nocPkg::numPorts-1:0] inValid;
  nocPkg::flitT inFlit [nocPkg::numPorts];
  logic [nocPkg::numPorts-1:0] inReady;
  logic outValid;
  nocPkg::outFlitT outFlit;
  logic outReady;

  stallModeT stallMode = ModeReady;
  pktDescT pktQ [nocPkg::numPorts][$];
  nocPkg::flitT expQ [nocPkg::numPorts][$];
  nocPkg::portIdT portOrder[$];
  int nextSeq [nocPkg::numPorts];
  int pushedFlits = 0;
  int acceptedFlits = 0;
  int receivedFlits = 0;
  int fullCycles = 0;
  int checks = 0;
  int errors = 0;
  int otherFails = 0;
  int remaining = 0;
  nocPkg::portIdT curSrc = nocPkg::PortLocal;

  always #50 clk = ~clk;

  routerOutputPort #(
    .fifoDepth(4)
  ) dut_i (
    .clk     (clk),
    .rst     (rst),
    .inValid (inValid),
    .inFlit  (inFlit),
    .inReady (inReady),
    .outValid(outValid),
    .outFlit (outFlit),
    .outReady(outReady)
  );

  // Head holds port, sequence and length while body payloads use a fixed formula
  function automatic flitListT expectPacket(input int port, input int seq, input int len);
    flitListT flits;
    nocPkg::flitT f;
    f.kind = nocPkg::Head;
    f.payload = {4'(port), 8'(seq), 4'(len)};
    flits.push_back(f);
    for (int k = 1; k < len; k++)
    begin
      f.kind = nocPkg::Body;
      f.payload = 16'(port * 4099 + seq * 257 + k * 31) ^ 16'hA5C3;
      flits.push_back(f);
    end
    return flits;
  endfunction

  task automatic checkFlit(input nocPkg::flitT got, input nocPkg::flitT exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAIL at %0t: flit %s %h, expected %s %h", $time,
               got.kind.name(), got.payload, exp.kind.name(), exp.payload);
    end
  endtask

  task automatic checkPort(input nocPkg::portIdT got, input nocPkg::portIdT exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAIL at %0t: source port %0d, expected %s", $time, got, exp.name());
    end
  endtask

  // One driver per input port, fed from its packet queue
  for (genvar g = 0; g < nocPkg::numPorts; g++)
  begin : drv_g
    logic drvValid;
    nocPkg::flitT drvFlit;

    assign inValid[g] = drvValid;
    assign inFlit[g] = drvFlit;

    initial
    begin
      pktDescT d;
      flitListT flits;
      bit taken;
      int tries;
      drvValid = 1'b0;
      drvFlit = '0;
      forever
      begin
        @(posedge clk);
        #1;
        if (pktQ[g].size() != 0)
        begin
          d = pktQ[g].pop_front();
          repeat (int'(d.gap))
          begin
            @(posedge clk);
            #1;
          end
          flits = expectPacket(g, int'(d.seq), int'(d.len));
          foreach (flits[k])
          begin
            drvValid = 1'b1;
            drvFlit = flits[k];
            taken = 1'b0;
            tries = 0;
            // inReady is stable between edges and holds for the next one
            while (!taken && tries < 1000)
            begin
              taken = inReady[g];
              tries++;
              @(posedge clk);
              #1;
            end
            if (!taken)
            begin
              otherFails++;
              $display("Port %0d gave up waiting for the input to become ready", g);
            end
          end
          drvValid = 1'b0;
        end
      end
    end
  end

  // Output back-pressure
  initial
  begin
    outReady = 1'b0;
    forever
    begin
      @(posedge clk);
      #1;
      case (stallMode)
        ModeReady: outReady = 1'b1;
        ModeHold:  outReady = 1'b0;
        ModeLight: outReady = $urandom_range(7, 0) != 0;
        default:   outReady = $urandom_range(3, 0) == 0;
      endcase
    end
  end

  // Monitor samples mid cycle where every signal is settled
  always @(negedge clk)
  begin
    nocPkg::outFlitT got;
    int p;
    if (!rst)
    begin
      for (int i = 0; i < nocPkg::numPorts; i++)
      begin
        if (inValid[i] && inReady[i])
          acceptedFlits++;
      end
      if (inReady != '1)
        fullCycles++;
      if (outValid && outReady)
      begin
        got = outFlit;
        p = int'(got.srcPort);
        receivedFlits++;
        if (remaining != 0)
        begin
          checkPort(got.srcPort, curSrc);
          remaining--;
        end
        else
        begin
          if (got.flit.kind != nocPkg::Head)
          begin
            errors++;
            $display("FAIL at %0t: flit after a packet end is not a head", $time);
          end
          if (portOrder.size() != 0)
            checkPort(got.srcPort, portOrder.pop_front());
          curSrc = got.srcPort;
          if (got.flit.kind == nocPkg::Head && got.flit.payload[3:0] > 4'd1)
            remaining = int'(got.flit.payload[3:0]) - 1;
        end
        if (p >= nocPkg::numPorts || expQ[p].size() == 0)
        begin
          errors++;
          $display("FAIL at %0t: flit from port %0d that was never sent", $time, p);
        end
        else
          checkFlit(got.flit, expQ[p].pop_front());
      end
    end
  end

  task automatic pushPacket(input int port, input int len, input int gap);
    pktDescT d;
    flitListT flits;
    d.seq = 16'(nextSeq[port]);
    d.len = 4'(len);
    d.gap = 4'(gap);
    nextSeq[port]++;
    pktQ[port].push_back(d);
    flits = expectPacket(port, int'(d.seq), len);
    foreach (flits[k])
    begin
      expQ[port].push_back(flits[k]);
    end
    pushedFlits += len;
  endtask

  function automatic bit drained();
    bit empty;
    empty = receivedFlits == pushedFlits;
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      if (expQ[i].size() != 0 || pktQ[i].size() != 0)
        empty = 1'b0;
    end
    return empty;
  endfunction

  task automatic waitDrained(input int limit, inout bit ok);
    int cyc;
    cyc = 0;
    while (!drained() && cyc < limit)
    begin
      @(negedge clk);
      #1;
      cyc++;
    end
    if (!drained())
    begin
      otherFails++;
      ok = 1'b0;
      $display("Timed out after %0d cycles with %0d of %0d flits received",
               limit, receivedFlits, pushedFlits);
    end
  endtask

  task automatic waitAccepted(input int limit, inout bit ok);
    int cyc;
    cyc = 0;
    while (acceptedFlits != pushedFlits && cyc < limit)
    begin
      @(negedge clk);
      #1;
      cyc++;
    end
    if (acceptedFlits != pushedFlits)
    begin
      otherFails++;
      ok = 1'b0;
      $display("Timed out with only %0d of %0d flits taken by the inputs",
               acceptedFlits, pushedFlits);
    end
  endtask

  task automatic waitOutReady(input logic level, inout bit ok);
    int cyc;
    cyc = 0;
    while (outReady !== level && cyc < 10)
    begin
      @(negedge clk);
      #1;
      cyc++;
    end
    if (outReady !== level)
    begin
      otherFails++;
      ok = 1'b0;
      $display("Timed out waiting for the output stall level to change");
    end
  endtask

  task automatic endTest(input int num, input string name, input int errStart, input bit ok);
    if (ok && errors == errStart)
      $display("Test %0d %s: ok", num, name);
    else
      $display("Test %0d %s: failed", num, name);
  endtask

  initial
  begin
    bit ok;
    int errStart;
    int fullStart;
    void'($urandom(32'h4342_47c0));
    ok = 1'b1;
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    errStart = errors;
    portOrder.push_back(nocPkg::PortNorth);
    pushPacket(1, 3, 0);
    waitDrained(200, ok);
    endTest(1, "single packet", errStart, ok);

    if (ok)
    begin
      errStart = errors;
      stallMode = ModeHold;
      waitOutReady(1'b0, ok);
      // North was served last, so each round starts at East
      for (int r = 0; r < 2; r++)
      begin
        for (int k = 0; k < nocPkg::numPorts; k++)
          portOrder.push_back(nocPkg::portIdT'((k + 2) % nocPkg::numPorts));
      end
      for (int p = 0; p < nocPkg::numPorts; p++)
      begin
        pushPacket(p, 1, 0);
        pushPacket(p, 1, 0);
      end
      waitAccepted(200, ok);
      stallMode = ModeReady;
      waitDrained(300, ok);
      endTest(2, "single-flit packets", errStart, ok);
    end

    if (ok)
    begin
      errStart = errors;
      // South goes last so the search starts at Local
      portOrder.push_back(nocPkg::PortSouth);
      pushPacket(4, 2, 0);
      waitDrained(200, ok);
      stallMode = ModeHold;
      waitOutReady(1'b0, ok);
      for (int p = 0; p < nocPkg::numPorts; p++)
      begin
        portOrder.push_back(nocPkg::portIdT'(p));
        pushPacket(p, int'($urandom_range(4, 1)), 0);
      end
      waitAccepted(200, ok);
      stallMode = ModeReady;
      waitDrained(300, ok);
      stallMode = ModeHold;
      waitOutReady(1'b0, ok);
      portOrder.push_back(nocPkg::PortLocal);
      portOrder.push_back(nocPkg::PortEast);
      portOrder.push_back(nocPkg::PortEast);
      pushPacket(2, 2, 0);
      pushPacket(2, 2, 0);
      pushPacket(0, int'($urandom_range(4, 1)), 0);
      waitAccepted(200, ok);
      stallMode = ModeReady;
      waitDrained(300, ok);
      endTest(3, "round-robin order", errStart, ok);
    end

    if (ok)
    begin
      errStart = errors;
      stallMode = ModeLight;
      for (int n = 0; n < 6; n++)
      begin
        for (int p = 0; p < nocPkg::numPorts; p++)
          pushPacket(p, int'($urandom_range(4, 1)), int'($urandom_range(3, 0)));
      end
      waitDrained(3000, ok);
      endTest(4, "wormhole contiguity", errStart, ok);
    end

    if (ok)
    begin
      errStart = errors;
      fullStart = fullCycles;
      stallMode = ModeHeavy;
      for (int n = 0; n < 8; n++)
      begin
        for (int p = 0; p < nocPkg::numPorts; p++)
          pushPacket(p, int'($urandom_range(4, 1)), 0);
      end
      waitDrained(5000, ok);
      if (fullCycles == fullStart)
      begin
        otherFails++;
        ok = 1'b0;
        $display("Back-pressure never filled an input FIFO");
      end
      stallMode = ModeReady;
      endTest(5, "back-pressure", errStart, ok);
    end

    $display("Checks %0d, mismatches %0d, other failures %0d", checks, errors, otherFails);
    if (ok && errors == 0 && otherFails == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* build.f */
src/nocPkg.sv
src/inputChannel.sv
src/switchArbiter.sv
src/routerOutputPort.sv
tests/outputPortTb.sv

/* Makefile */
# Verilator build of the output-port testbench

VERILATOR ?= verilator
TOP       ?= outputPortTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
